// File: hw/apu_pkg.sv
// ##############################
// APU shared definitions
// Widths, payload types and the memory and control words
// ##############################
package apu_pkg;

  localparam int ADDR_BITS     = 29;  // Address of a 64-bit word
  localparam int CHUNK_BITS    = 64;  // One memory word
  localparam int SAMPLE_BITS   = 8;   // Mono PCM sample
  localparam int I2S_WORD_BITS = 16;  // Bits per channel word

  typedef logic [ADDR_BITS-1:0]     mem_addr_t;
  typedef logic [CHUNK_BITS-1:0]    chunk_t;     // Eight samples, byte 0 first
  typedef logic [SAMPLE_BITS-1:0]   sample_t;
  typedef logic [I2S_WORD_BITS-1:0] pcm_t;       // Sample then eight zero bits

  // ##############################
  // Software control word
  // ##############################
  typedef struct packed {
    logic apu_en;      // Playback enable
    logic irq_en_set;  // Arm the buffer interrupt
    logic irq_ack;     // Disarm and clear the interrupt
  } apu_control_t;

  // ##############################
  // Memory read port
  // ##############################
  typedef struct packed {
    logic      read_en;  // Held until ack
    mem_addr_t addr;
  } mem_req_t;

  typedef struct packed {
    logic   ack;   // Data valid
    logic   busy;  // Request not accepted this cycle
    chunk_t data;
  } mem_rsp_t;

endpackage

// File: hw/apu_ctrl.sv
// ##############################
// APU control registers
// Enable, interrupt arm bit and the single queued buffer base
// ##############################
`timescale 1ns/1ns

module apu_ctrl (
  input  logic                  clock,
  input  logic                  reset_l,
  input  apu_pkg::apu_control_t control,
  input  logic                  control_valid,  // One-cycle strobe
  input  apu_pkg::mem_addr_t    buf_base,
  input  logic                  buf_valid,      // One-cycle strobe
  input  logic                  base_ack,       // Fetcher took the queued base
  output apu_pkg::mem_addr_t    queued_base,
  output logic                  queued_valid,
  output logic                  apu_en,
  output logic                  buf_irq
);

  logic irq_en;             // Interrupt armed
  logic irq_ack;
  logic irq_set;
  logic next_apu_en;
  logic next_irq_en;
  logic next_queued_valid;

  assign irq_ack     = control_valid & control.irq_ack;
  assign irq_set     = control_valid & control.irq_en_set;
  assign next_apu_en = control_valid ? control.apu_en : apu_en;

  // Ack beats set when both come in one write
  assign next_irq_en = irq_ack ? 1'b0 : (irq_set ? 1'b1 : irq_en);

  // A new base wins over the fetcher taking the old one
  always_comb begin
    next_queued_valid = queued_valid;
    if (buf_valid) begin
      next_queued_valid = 1'b1;
    end else if (base_ack) begin
      next_queued_valid = 1'b0;
    end
  end

  // ##############################
  // State registers
  // ##############################
  always_ff @(posedge clock or negedge reset_l) begin
    if (!reset_l) begin
      apu_en       <= 1'b0;
      irq_en       <= 1'b0;
      queued_valid <= 1'b0;
      buf_irq      <= 1'b0;
    end else begin
      apu_en       <= next_apu_en;
      irq_en       <= next_irq_en;
      queued_valid <= next_queued_valid;
      buf_irq      <= next_irq_en & ~next_queued_valid;  // Ask for a buffer
    end
  end

  always_ff @(posedge clock) begin
    if (buf_valid) begin
      queued_base <= buf_base;  // Only one slot, a later write replaces it
    end
  end

endmodule

// File: hw/sample_fetcher.sv
// ##############################
// Sample fetcher
// Reads a buffer one 64-bit chunk at a time and hands chunks to the
// player, moving on to the queued buffer at the end of each one
// ##############################
`timescale 1ns/1ns

module sample_fetcher #(
  parameter int BUF_CHUNKS = 512
) (
  input  logic               clock,
  input  logic               reset_l,
  input  apu_pkg::mem_addr_t queued_base,
  input  logic               queued_valid,  // Level from apu_ctrl
  output logic               base_ack,      // One-cycle pulse
  output apu_pkg::mem_req_t  mem_req,
  input  apu_pkg::mem_rsp_t  mem_rsp,
  output apu_pkg::chunk_t    chunk,
  output logic               chunk_valid,   // Level until chunk_ack
  input  logic               chunk_ack
);

  localparam int CNT_BITS = $clog2(BUF_CHUNKS + 1);

  logic [CNT_BITS-1:0] chunks_left;  // Reads still owed on this buffer
  apu_pkg::mem_addr_t  addr;         // Next chunk address
  logic                read_en;
  logic                take_base;
  logic                issue_read;
  logic                rsp_done;

  assign rsp_done = read_en & mem_rsp.ack;  // Stray acks ignored

  // Idle or just past the last chunk
  assign take_base = (chunks_left == '0) & queued_valid;

  // Chunk register free, or freed this cycle by the player
  assign issue_read = (chunks_left != '0) & ~read_en & (~chunk_valid | chunk_ack);

  assign mem_req.read_en = read_en;
  assign mem_req.addr    = addr;

  // ##############################
  // Buffer walk and read request
  // ##############################
  always_ff @(posedge clock or negedge reset_l) begin
    if (!reset_l) begin
      chunks_left <= '0;
      addr        <= '0;
      read_en     <= 1'b0;
      base_ack    <= 1'b0;
    end else begin
      base_ack <= take_base;
      if (take_base) begin
        addr        <= queued_base;              // Start of the new buffer
        chunks_left <= CNT_BITS'(BUF_CHUNKS);
      end
      if (issue_read) begin
        read_en <= 1'b1;                         // Held through busy
      end else if (rsp_done) begin
        read_en     <= 1'b0;
        addr        <= addr + 1'b1;
        chunks_left <= chunks_left - 1'b1;
      end
    end
  end

  // ##############################
  // Chunk register toward the player
  // ##############################
  always_ff @(posedge clock or negedge reset_l) begin
    if (!reset_l) begin
      chunk_valid <= 1'b0;
    end else if (rsp_done) begin
      chunk_valid <= 1'b1;
    end else if (chunk_ack) begin
      chunk_valid <= 1'b0;  // Drops the cycle after the ack
    end
  end

  always_ff @(posedge clock) begin
    if (rsp_done) begin
      chunk <= mem_rsp.data;
    end
  end

endmodule

// File: hw/chunk_player.sv
// ##############################
// Chunk player
// Hands out one byte of the held chunk per sample request
// ##############################
`timescale 1ns/1ns

module chunk_player (
  input  logic             clock,
  input  logic             reset_l,
  input  apu_pkg::chunk_t  chunk,
  input  logic             chunk_valid,
  output logic             chunk_ack,   // One-cycle pulse on copy
  input  logic             sample_req,  // One pulse per I2S frame
  output apu_pkg::sample_t sample
);

  apu_pkg::chunk_t held_chunk;  // Local copy being played
  logic            held;        // held_chunk has bytes left
  logic [2:0]      byte_idx;    // Next byte to play
  logic            load;

  assign load = ~held & chunk_valid & ~chunk_ack;  // Skip the stale valid cycle

  // ##############################
  // Byte sequencing
  // ##############################
  always_ff @(posedge clock or negedge reset_l) begin
    if (!reset_l) begin
      held      <= 1'b0;
      byte_idx  <= '0;
      sample    <= '0;
      chunk_ack <= 1'b0;
    end else begin
      chunk_ack <= load;
      if (sample_req && held) begin
        sample   <= held_chunk[{byte_idx, 3'b000} +: $bits(apu_pkg::sample_t)];
        byte_idx <= byte_idx + 1'b1;
        if (byte_idx == 3'd7) begin
          held <= 1'b0;  // Last byte gone, fetch the next chunk
        end
      end else if (load) begin
        held     <= 1'b1;
        byte_idx <= '0;
      end
      // Starved requests keep the last sample
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      held_chunk <= chunk;
    end
  end

endmodule

// File: hw/ws_sync.sv
// ##############################
// Word select synchronizer
// Brings i2s_ws into the system clock and pulses on its rise
// ##############################
`timescale 1ns/1ns

module ws_sync (
  input  logic clock,
  input  logic reset_l,
  input  logic i2s_ws,      // From the i2s_clk domain
  output logic sample_req   // One-cycle pulse
);

  logic ws_meta;  // First stage, may go metastable
  logic ws_sync;  // Safe to use
  logic ws_prev;  // For the edge detect

  always_ff @(posedge clock or negedge reset_l) begin
    if (!reset_l) begin
      ws_meta    <= 1'b0;
      ws_sync    <= 1'b0;
      ws_prev    <= 1'b0;
      sample_req <= 1'b0;
    end else begin
      ws_meta    <= i2s_ws;
      ws_sync    <= ws_meta;
      ws_prev    <= ws_sync;
      sample_req <= ws_sync & ~ws_prev;  // Third edge after the rise
    end
  end

endmodule

// File: hw/i2s_tx.sv
// ##############################
// I2S transmitter
// Word select generation and MSB-first shift out on i2s_clk
// ##############################
`timescale 1ns/1ns

module i2s_tx (
  input  logic          i2s_clk,
  input  logic          reset_l,
  input  apu_pkg::pcm_t pcm,      // Settled long before word select falls
  output logic          i2s_ws,   // Low is left
  output logic          i2s_sd
);

  localparam int CNT_BITS = $clog2(apu_pkg::I2S_WORD_BITS);

  logic [CNT_BITS-1:0] bit_cnt;
  apu_pkg::pcm_t       shift_reg;
  apu_pkg::pcm_t       latched;    // Frame value, reused for right word
  logic                word_end;

  assign word_end = (bit_cnt == CNT_BITS'(apu_pkg::I2S_WORD_BITS - 1));

  // ##############################
  // Framing and shifter
  // ##############################
  always_ff @(posedge i2s_clk or negedge reset_l) begin
    if (!reset_l) begin
      bit_cnt   <= '0;
      i2s_ws    <= 1'b0;
      i2s_sd    <= 1'b0;
      shift_reg <= '0;
      latched   <= '0;
    end else begin
      bit_cnt <= word_end ? '0 : bit_cnt + 1'b1;
      i2s_sd  <= shift_reg[apu_pkg::I2S_WORD_BITS-1];  // One bit clock behind ws
      if (word_end) begin
        i2s_ws <= ~i2s_ws;
        if (i2s_ws) begin
          latched   <= pcm;       // Falling ws starts a new frame
          shift_reg <= pcm;
        end else begin
          shift_reg <= latched;   // Right word repeats the left
        end
      end else begin
        shift_reg <= shift_reg << 1;
      end
    end
  end

endmodule

// File: hw/apu.sv
// ##############################
// Audio playback unit
// Fetches 8-bit PCM from memory and plays it over I2S
// ##############################
`timescale 1ns/1ns

module apu #(
  parameter int BUF_CHUNKS = 512  // Chunks per buffer
) (
  input  logic                  clock,
  input  logic                  reset_l,
  input  logic                  i2s_clk,
  input  apu_pkg::apu_control_t control,
  input  logic                  control_valid,
  input  apu_pkg::mem_addr_t    buf_base,
  input  logic                  buf_valid,
  output logic                  buf_irq,
  output apu_pkg::mem_req_t     mem_req,
  input  apu_pkg::mem_rsp_t     mem_rsp,
  output logic                  i2s_ws,
  output logic                  i2s_sd
);

  apu_pkg::mem_addr_t queued_base;
  logic               queued_valid;
  logic               base_ack;
  logic               apu_en;
  apu_pkg::chunk_t    chunk;
  logic               chunk_valid;
  logic               chunk_ack;
  logic               sample_req;
  apu_pkg::sample_t   sample;
  apu_pkg::pcm_t      pcm;           // Crosses into i2s_clk unsynchronized

  // Same sample on both channels, silent when disabled
  assign pcm = apu_en ? {sample, 8'h00} : '0;

  apu_ctrl u_ctrl (
    .clock, .reset_l, .control, .control_valid, .buf_base, .buf_valid,
    .base_ack, .queued_base, .queued_valid, .apu_en, .buf_irq
  );

  sample_fetcher #(.BUF_CHUNKS(BUF_CHUNKS)) u_fetcher (
    .clock, .reset_l, .queued_base, .queued_valid, .base_ack,
    .mem_req, .mem_rsp, .chunk, .chunk_valid, .chunk_ack
  );

  chunk_player u_player (
    .clock, .reset_l, .chunk, .chunk_valid, .chunk_ack, .sample_req, .sample
  );

  ws_sync u_ws_sync (
    .clock, .reset_l, .i2s_ws, .sample_req
  );

  i2s_tx u_i2s_tx (
    .i2s_clk, .reset_l, .pcm, .i2s_ws, .i2s_sd
  );

endmodule

// File: dv/apu_tb_clock.sv
// ##############################
// Testbench clocks and reset
// ##############################
`timescale 1ns/1ns

module apu_tb_clock (
  output logic clock,
  output logic i2s_clk,
  output logic reset_l
);

  localparam int CLOCK_HALF   = 50;   // 100 ns system clock
  localparam int I2S_HALF     = 200;  // 400 ns bit clock
  localparam int RESET_CYCLES = 5;

  initial begin
    clock = 1'b0;
    forever #CLOCK_HALF clock = ~clock;
  end

  initial begin
    i2s_clk = 1'b0;
    forever #I2S_HALF i2s_clk = ~i2s_clk;  // Edges fall between clock edges
  end

  initial begin
    reset_l = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #10 reset_l = 1'b1;
  end

endmodule

// File: dv/apu_tb_mem.sv
// ##############################
// Memory model
// One-cycle read with optional random busy
// ##############################
`timescale 1ns/1ns

module apu_tb_mem #(
  parameter int MEM_WORDS = 4096
) (
  input  logic              clock,
  input  logic              reset_l,
  input  logic              random_busy,  // Enables the busy generator
  input  apu_pkg::mem_req_t mem_req,
  output apu_pkg::mem_rsp_t mem_rsp
);

  localparam int IDX_BITS = $clog2(MEM_WORDS);

  apu_pkg::chunk_t words [MEM_WORDS];  // Filled by the testbench
  int              seed = 32'h0804dfad;
  logic            accept;

  // No second accept while the ack is on the bus
  assign accept = mem_req.read_en & ~mem_rsp.busy & ~mem_rsp.ack;

  always @(posedge clock or negedge reset_l) begin
    if (!reset_l) begin
      mem_rsp <= '0;
    end else begin
      mem_rsp.ack <= accept;  // Data one cycle after acceptance
      if (accept) begin
        mem_rsp.data <= words[mem_req.addr[IDX_BITS-1:0]];
      end
      mem_rsp.busy <= random_busy ? 1'($random(seed)) : 1'b0;
    end
  end

endmodule

// File: dv/apu_properties.sv
// ##############################
// APU protocol assertions
// Interrupt ack, read request hold and word select period
// ##############################
`timescale 1ns/1ns

module apu_properties (
  input logic                  clock,
  input logic                  reset_l,
  input logic                  i2s_clk,
  input apu_pkg::apu_control_t control,
  input logic                  control_valid,
  input logic                  buf_irq,
  input apu_pkg::mem_req_t     mem_req,
  input apu_pkg::mem_rsp_t     mem_rsp,
  input logic                  i2s_ws
);

  logic [3:0] ws_cnt;  // Bit clocks into the current word

  always_ff @(posedge i2s_clk or negedge reset_l) begin
    if (!reset_l) begin
      ws_cnt <= '0;
    end else begin
      ws_cnt <= ws_cnt + 1'b1;  // Wraps every 16
    end
  end

  irq_ack_clears: assert property (@(posedge clock) disable iff (!reset_l)
    (control_valid && control.irq_ack) |=> !buf_irq)
    else $error("buf_irq still high after irq_ack");

  req_held: assert property (@(posedge clock) disable iff (!reset_l)
    (mem_req.read_en && !mem_rsp.ack) |=> (mem_req.read_en && $stable(mem_req.addr)))
    else $error("mem_req dropped or changed before ack");

  ws_toggles: assert property (@(posedge i2s_clk) disable iff (!reset_l)
    (ws_cnt == 4'd15) |=> $changed(i2s_ws))
    else $error("i2s_ws did not toggle after 16 bit clocks");

  ws_holds: assert property (@(posedge i2s_clk) disable iff (!reset_l)
    (ws_cnt != 4'd15) |=> $stable(i2s_ws))
    else $error("i2s_ws toggled early");

endmodule

// File: dv/apu_tb.sv
// ##############################
// APU testbench
// Directed playback, queueing, interrupt, back-pressure and disable tests
// ##############################
`timescale 1ns/1ns

module apu_tb;

  localparam int BUF_CHUNKS  = 4;
  localparam int FRAME_NS    = 2 * apu_pkg::I2S_WORD_BITS * 400;  // 12.8 us
  localparam int EXP_FRAMES  = 205;
  localparam int SKIP_LIMIT  = 6;  // Frames allowed before a stream starts
  localparam int WATCHDOG_NS = (EXP_FRAMES + 20) * FRAME_NS;

  logic                  clock;
  logic                  i2s_clk;
  logic                  reset_l;
  apu_pkg::apu_control_t control;
  logic                  control_valid;
  apu_pkg::mem_addr_t    buf_base;
  logic                  buf_valid;
  logic                  buf_irq;
  apu_pkg::mem_req_t     mem_req;
  apu_pkg::mem_rsp_t     mem_rsp;
  logic                  i2s_ws;
  logic                  i2s_sd;
  logic                  random_busy;

  logic [31:0] frames [$];  // {left, right} per frame
  logic [7:0]  exp_bytes [$];
  logic [15:0] rx_shift;
  logic [15:0] rx_left;
  logic        rx_ws_prev;
  logic [7:0]  prev_last;    // Byte repeated when the last stream ended
  int          errors;
  int          checks;

  apu_tb_clock u_clock (.clock, .i2s_clk, .reset_l);

  apu_tb_mem u_mem (.clock, .reset_l, .random_busy, .mem_req, .mem_rsp);

  apu #(.BUF_CHUNKS(BUF_CHUNKS)) uut (
    .clock, .reset_l, .i2s_clk, .control, .control_valid, .buf_base, .buf_valid,
    .buf_irq, .mem_req, .mem_rsp, .i2s_ws, .i2s_sd
  );

  bind apu apu_properties u_props (
    .clock(clock), .reset_l(reset_l), .i2s_clk(i2s_clk), .control(control),
    .control_valid(control_valid), .buf_irq(buf_irq), .mem_req(mem_req),
    .mem_rsp(mem_rsp), .i2s_ws(i2s_ws)
  );

  // ##############################
  // I2S receiver
  // ##############################
  always @(negedge i2s_clk) begin  // Midway between shift edges
    if (reset_l) begin
      rx_shift = {rx_shift[14:0], i2s_sd};
      if (i2s_ws != rx_ws_prev) begin
        if (!rx_ws_prev) begin
          rx_left = rx_shift;                  // Left word done
        end else begin
          frames.push_back({rx_left, rx_shift});
        end
      end
      rx_ws_prev = i2s_ws;
    end
  end

  function automatic apu_pkg::chunk_t fill_word(input apu_pkg::mem_addr_t a);
    apu_pkg::chunk_t w;
    logic [31:0]     lin;
    logic [7:0]      b;
    for (int i = 0; i < 8; i++) begin
      lin = {a, 3'(i)};
      b   = lin[7:0] ^ a[15:8] ^ a[23:16] ^ {3'b000, a[28:24]};
      if (b == 8'h00) begin
        b = 8'h5a;                             // Keep every byte nonzero
      end
      w[i*8 +: 8] = b;
    end
    return w;
  endfunction

  task automatic tick(input int n);
    repeat (n) @(posedge clock);
    #10;                                       // Drive point
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED time=%0t %s: expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic write_control(input logic en, input logic set, input logic ack);
    tick(1);                                   // Start on a drive point
    control       = '{apu_en: en, irq_en_set: set, irq_ack: ack};
    control_valid = 1'b1;
    tick(1);
    control_valid = 1'b0;
  endtask

  task automatic write_base(input apu_pkg::mem_addr_t base);
    tick(1);                                   // Start on a drive point
    buf_base  = base;
    buf_valid = 1'b1;
    tick(1);
    buf_valid = 1'b0;
  endtask

  task automatic add_buffer(input apu_pkg::mem_addr_t base);
    apu_pkg::chunk_t w;
    for (int c = 0; c < BUF_CHUNKS; c++) begin
      w = u_mem.words[int'(base) + c];
      for (int i = 0; i < 8; i++) begin
        exp_bytes.push_back(w[i*8 +: 8]);      // Byte 0 plays first
      end
    end
  endtask

  task automatic next_frame(output logic [15:0] l, output logic [15:0] r);
    while (frames.size() == 0) begin
      @(negedge i2s_clk);
    end
    {l, r} = frames.pop_front();
  endtask

  task automatic check_frame(input logic [15:0] l, input logic [15:0] r,
                             input logic [7:0] b);
    check_value("i2s_sd left word", l, {b, 8'h00});
    check_value("i2s_sd right word", r, {b, 8'h00});
  endtask

  // Skips the old repeat, then expects exp_bytes and repeats
  task automatic check_stream(input int repeats);
    logic [15:0] l;
    logic [15:0] r;
    int          skipped;
    skipped = 0;
    next_frame(l, r);
    while (l[15:8] != exp_bytes[0] && skipped < SKIP_LIMIT) begin
      check_value("i2s_sd leading word", l, {prev_last, 8'h00});
      skipped++;
      next_frame(l, r);
    end
    assert (skipped < SKIP_LIMIT) else begin
      errors++;
      $display("Playback did not start within %0d frames at time %0t", SKIP_LIMIT, $time);
    end
    if (skipped >= SKIP_LIMIT) begin
      exp_bytes.delete();
      return;
    end
    check_frame(l, r, exp_bytes[0]);
    for (int k = 1; k < exp_bytes.size(); k++) begin
      next_frame(l, r);
      check_frame(l, r, exp_bytes[k]);
    end
    prev_last = exp_bytes[exp_bytes.size()-1];
    for (int k = 0; k < repeats; k++) begin
      next_frame(l, r);
      check_frame(l, r, prev_last);           // Starved player repeats
    end
    exp_bytes.delete();
  endtask

  // ##############################
  // Directed tests
  // ##############################
  task automatic test_reset();
    logic [15:0] l;
    logic [15:0] r;
    check_value("buf_irq", 16'(buf_irq), 16'h0);
    check_value("mem_req.read_en", 16'(mem_req.read_en), 16'h0);
    frames.delete();
    for (int k = 0; k < 3; k++) begin
      next_frame(l, r);
      check_frame(l, r, 8'h00);                // Disabled output is silent
    end
  endtask

  task automatic test_single(input apu_pkg::mem_addr_t base);
    frames.delete();
    add_buffer(base);
    write_control(1'b1, 1'b0, 1'b0);
    write_base(base);
    check_stream(3);
  endtask

  task automatic test_double(input apu_pkg::mem_addr_t base_a,
                             input apu_pkg::mem_addr_t base_b);
    frames.delete();
    add_buffer(base_a);
    add_buffer(base_b);
    write_base(base_a);
    tick(20);                                  // A taken, B queued behind it
    write_base(base_b);
    check_stream(2);
  endtask

  task automatic test_irq(input apu_pkg::mem_addr_t base);
    int k;
    frames.delete();
    add_buffer(base);
    write_control(1'b1, 1'b1, 1'b0);
    check_value("buf_irq", 16'(buf_irq), 16'h1);
    write_base(base);
    check_value("buf_irq", 16'(buf_irq), 16'h0);
    k = 0;
    while (!buf_irq && k < 10) begin
      tick(1);
      k++;
    end
    check_value("buf_irq", 16'(buf_irq), 16'h1);  // Base taken, slot empty
    write_control(1'b1, 1'b0, 1'b1);
    check_value("buf_irq", 16'(buf_irq), 16'h0);
    tick(20);
    check_value("buf_irq", 16'(buf_irq), 16'h0);
    check_stream(2);
  endtask

  task automatic test_backpressure(input apu_pkg::mem_addr_t base);
    random_busy = 1'b1;
    test_single(base);
    random_busy = 1'b0;
  endtask

  task automatic test_disable();
    logic [15:0] l;
    logic [15:0] r;
    write_control(1'b0, 1'b0, 1'b0);
    frames.delete();
    next_frame(l, r);                          // Latched before the write
    for (int k = 0; k < 3; k++) begin
      next_frame(l, r);
      check_frame(l, r, 8'h00);
    end
  endtask

  initial begin
    control       = '0;
    control_valid = 1'b0;
    buf_base      = '0;
    buf_valid     = 1'b0;
    random_busy   = 1'b0;
    rx_shift      = '0;
    rx_left       = '0;
    rx_ws_prev    = 1'b0;
    prev_last     = 8'h00;
    errors        = 0;
    checks        = 0;
    for (int a = 0; a < 4096; a++) begin
      u_mem.words[a] = fill_word(29'(a));
    end
    @(posedge reset_l);
    tick(2);
    test_reset();
    test_single(29'h100);
    test_double(29'h204, 29'h308);
    test_irq(29'h410);
    test_backpressure(29'h100);
    test_disable();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // ##############################
  // Watchdog
  // ##############################
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: apu.f
hw/apu_pkg.sv
hw/apu_ctrl.sv
hw/sample_fetcher.sv
hw/chunk_player.sv
hw/ws_sync.sv
hw/i2s_tx.sv
hw/apu.sv
dv/apu_tb_clock.sv
dv/apu_tb_mem.sv
dv/apu_properties.sv
dv/apu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the APU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module apu_tb \
  -f apu.f \
  -o apu_sim

./obj_dir/apu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
  exit 0
fi
exit 1
